// File: logic/fdc_pkg.sv
package fdc_pkg;

	// host register map, 3-bit address
	localparam logic [2:0] a_command_status = 3'd0; // command on write, status on read
	localparam logic [2:0] a_track          = 3'd1;
	localparam logic [2:0] a_sector         = 3'd2;
	localparam logic [2:0] a_data           = 3'd3;

	// command byte sent to the image server
	localparam logic [7:0] cmd_read = 8'h10; // bit 0 carries the side
	localparam logic [7:0] cmd_ack  = 8'h80;
	localparam logic [7:0] cmd_idle = 8'h00;

	// image server status bits
	localparam int ws_done = 0;
	localparam int ws_ok   = 1; // only meaningful with ws_done

	// status register bits
	localparam int sb_busy     = 0;
	localparam int sb_drq      = 1; // index pulse on type I commands
	localparam int sb_track0   = 2;
	localparam int sb_notfound = 4;
	localparam int sb_headload = 5;

	// disk geometry
	localparam logic [15:0] sector_size       = 16'd512;
	localparam logic [7:0]  sectors_per_track = 8'd10; // sectors numbered from 1
	localparam logic [7:0]  track_count       = 8'd80;

	// sector buffer address width
	localparam int buff_addr_w = 9;

	// Image content rule for the emulated disk:
	// byte i of a sector = i[7:0] ^ sector ^ head track,
	// with bit 7 flipped on side 1.
	// Only the image server generates it.

endpackage

// File: logic/head_positioner.sv
`timescale 1ns/1ps

module head_positioner (
	input  logic       clk,
	input  logic       clken,
	input  logic       reset_n,
	input  logic       restore,
	input  logic       seek,
	input  logic       step,
	input  logic       dir_given,
	input  logic       dir,
	input  logic [7:0] seek_target,
	output logic [7:0] head_track,
	output logic [7:0] next_track
);
	logic step_dir;  // 1 = outward, toward track 0
	logic eff_dir;

	// a step command may name its direction, otherwise the last one holds
	assign eff_dir = dir_given ? dir : step_dir;
	assign next_track = eff_dir ? head_track - 8'd1 : head_track + 8'd1;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			head_track <= 8'hff;  // unknown until a restore
			step_dir <= 1'b0;
		end else if (clken) begin
			if (restore) begin
				head_track <= 8'd0;
				step_dir <= 1'b1;  // restore moves outward
			end else if (seek) begin
				head_track <= seek_target;
				step_dir <= seek_target < head_track;
			end else if (step) begin
				head_track <= next_track;
				if (dir_given)
					step_dir <= dir;
			end
		end
	end

endmodule

// File: logic/sector_buffer.sv
`timescale 1ns/1ps

module sector_buffer import fdc_pkg::*; (
	input  logic                   clk,
	input  logic                   wr_en,
	input  logic [buff_addr_w-1:0] wr_addr,
	input  logic [7:0]             wr_data,
	input  logic                   rd_en,
	input  logic [buff_addr_w-1:0] rd_addr,
	output logic [7:0]             rd_data
);
	// one sector of bytes, maps onto a single block RAM
	logic [7:0] mem [0:(1 << buff_addr_w) - 1];

	// server side
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// controller side, data one clk after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: logic/disk_image_server.sv
`timescale 1ns/1ps

module disk_image_server import fdc_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic [7:0]             cpu_command,
	input  logic [7:0]             sector,
	input  logic [7:0]             head_track,
	output logic [7:0]             cpu_status,
	output logic                   wr_en,
	output logic [buff_addr_w-1:0] wr_addr,
	output logic [7:0]             wr_data
);
	typedef enum logic [1:0] {
		sv_idle,
		sv_fill,
		sv_report
	} state_t;

	state_t                 state;
	logic [buff_addr_w-1:0] count;  // byte being written
	logic                   side;
	logic                   done;
	logic                   ok;
	logic                   request;
	logic                   valid;
	logic [7:0]             pattern;

	assign request = cpu_command[7:1] == cmd_read[7:1];  // either side
	assign valid = sector != 8'd0 && sector <= sectors_per_track &&
		head_track < track_count;

	// sector content, see the package for the rule
	assign pattern = count[7:0] ^ sector ^ head_track ^ {side, 7'b0};

	always_comb begin
		cpu_status = '0;
		cpu_status[ws_done] = done;
		cpu_status[ws_ok] = ok;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= sv_idle;
			count <= '0;
			side <= 1'b0;
			done <= 1'b0;
			ok <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			case (state)
			sv_idle: begin
				if (request) begin
					side <= cpu_command[0];
					count <= '0;
					ok <= valid;
					// a bad request goes straight to report
					state <= valid ? sv_fill : sv_report;
				end
			end
			sv_fill: begin
				wr_en <= 1'b1;
				count <= count + 1'b1;
				if (&count)
					state <= sv_report;
			end
			sv_report: begin
				wr_en <= 1'b0;  // last byte lands on this edge
				done <= 1'b1;
				if (done && cpu_command == cmd_ack) begin
					done <= 1'b0;
					ok <= 1'b0;
					state <= sv_idle;
				end
			end
			default: state <= sv_idle;
			endcase
		end
	end

	// address and data line up with wr_en
	always_ff @(posedge clk) begin
		wr_addr <= count;
		wr_data <= pattern;
	end

endmodule

// File: logic/fdc_control.sv
`timescale 1ns/1ps

module fdc_control import fdc_pkg::*; (
	input  logic                   clk,
	input  logic                   clken,
	input  logic                   reset_n,
	input  logic                   rd,
	input  logic                   wr,
	input  logic [2:0]             addr,
	input  logic [7:0]             idata,
	output logic [7:0]             odata,
	output logic                   restore,
	output logic                   seek,
	output logic                   step,
	output logic                   dir_given,
	output logic                   dir,
	output logic [7:0]             seek_target,
	input  logic [7:0]             head_track,
	input  logic [7:0]             next_track,
	output logic [7:0]             cpu_command,
	input  logic [7:0]             cpu_status,
	output logic [7:0]             sector,
	output logic                   buff_rd_en,
	output logic [buff_addr_w-1:0] buff_rd_addr,
	input  logic [7:0]             buff_rd_data,
	output logic [7:0]             status,
	output logic                   irq,
	output logic                   drq
);
	typedef enum logic [1:0] {
		st_ready,
		st_wait_server,
		st_read_fetch,  // buffer read in flight
		st_read_data
	} state_t;

	state_t      state;
	logic [7:0]  track_reg;
	logic [15:0] byte_count;  // bytes left in the current sector
	logic [15:0] count_next;
	logic        side;
	logic        multi;
	logic        busy;
	logic        cmd_wr;

	assign busy = status[sb_busy];
	assign count_next = byte_count - 16'd1;

	// command register write accepted this cycle
	assign cmd_wr = clken && state == st_ready && !rd && wr &&
		addr == a_command_status && !busy;

	// head pulses leave in the same cycle as the command write
	assign restore = cmd_wr && idata[7:4] == 4'h0;
	assign seek = cmd_wr && idata[7:4] == 4'h1 && track_reg != head_track; // skip a null move
	assign step = cmd_wr && !idata[7] && idata[6:5] != 2'b00;  // commands 2 to 7
	assign dir_given = idata[6];
	assign dir = idata[5];
	assign seek_target = track_reg;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= st_ready;
			track_reg <= '0;
			sector <= '0;
			status <= '0;
			irq <= 1'b0;
			drq <= 1'b0;
			odata <= '0;
			cpu_command <= cmd_idle;
			buff_rd_en <= 1'b0;
			buff_rd_addr <= '0;
			byte_count <= '0;
			side <= 1'b0;
			multi <= 1'b0;
		end else if (clken) begin
			case (state)
			st_ready: begin
				if (rd) begin
					case (addr)
					a_command_status: odata <= status;
					a_track:          odata <= track_reg;
					a_sector:         odata <= sector;
					a_data: begin
						if (drq) begin  // nothing to hand out otherwise
							buff_rd_en <= 1'b1;
							state <= st_read_fetch;
						end
					end
					default: ;
					endcase
				end else if (wr && !busy) begin
					// while busy every write is refused
					case (addr)
					a_track:  track_reg <= idata;
					a_sector: sector <= idata;
					a_command_status: begin
						case (idata[7:4])
						4'h0: begin  // restore
							track_reg <= '0;
							status <= '0;
							status[sb_drq] <= 1'b1;
							status[sb_track0] <= 1'b1;
							status[sb_headload] <= idata[3];
							irq <= 1'b1;
						end
						4'h1: begin  // seek to the track register
							status <= '0;
							status[sb_drq] <= 1'b1;
							status[sb_track0] <= track_reg == 8'd0;
							status[sb_headload] <= idata[3];
							irq <= 1'b1;
						end
						4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
							if (idata[4])  // update flag
								track_reg <= next_track;
							status <= '0;
							status[sb_drq] <= 1'b1;
							status[sb_track0] <= next_track == 8'd0;
							status[sb_headload] <= idata[3];
							irq <= 1'b1;
						end
						4'h8, 4'h9: begin  // read sector, bit 4 = multi
							cpu_command <= cmd_read | {7'b0, idata[3]};
							status <= '0;
							status[sb_busy] <= 1'b1;
							irq <= 1'b0;
							side <= idata[3];
							multi <= idata[4];
							state <= st_wait_server;
						end
						default: ;  // write, read address, track ops, force int
						endcase
					end
					default: ;
					endcase
				end
			end
			st_wait_server: begin
				if (cpu_status[ws_done]) begin
					cpu_command <= cmd_ack;
					state <= st_ready;
					if (cpu_status[ws_ok]) begin
						status[sb_drq] <= 1'b1;
						drq <= 1'b1;
						byte_count <= sector_size;
						buff_rd_addr <= '0;
					end else begin
						status[sb_busy] <= 1'b0;
						status[sb_notfound] <= 1'b1;
						irq <= 1'b1;
						multi <= 1'b0;
					end
				end
			end
			st_read_fetch: begin
				buff_rd_en <= 1'b0;
				state <= st_read_data;
			end
			st_read_data: begin
				odata <= buff_rd_data;
				buff_rd_addr <= buff_rd_addr + 1'b1;
				byte_count <= count_next;
				state <= st_ready;
				if (count_next == 16'd0) begin
					drq <= 1'b0;
					status[sb_drq] <= 1'b0;
					if (multi && sector < sectors_per_track) begin
						// go on with the next sector, busy stays up
						sector <= sector + 8'd1;
						cpu_command <= cmd_read | {7'b0, side};
						state <= st_wait_server;
					end else begin
						status[sb_busy] <= 1'b0;
						irq <= 1'b1;
						multi <= 1'b0;
					end
				end
			end
			default: state <= st_ready;
			endcase
		end
	end

endmodule

// File: logic/fdc_subsystem.sv
`timescale 1ns/1ps

module fdc_subsystem import fdc_pkg::*; (
	input  logic       clk,
	input  logic       clken,
	input  logic       reset_n,
	input  logic       rd,
	input  logic       wr,
	input  logic [2:0] addr,
	input  logic [7:0] idata,
	output logic [7:0] odata,
	output logic [7:0] track,
	output logic [7:0] sector,
	output logic [7:0] status,
	output logic       irq,
	output logic       drq
);
	// head positioner
	logic                   restore;
	logic                   seek;
	logic                   step;
	logic                   dir_given;
	logic                   dir;
	logic [7:0]             seek_target;
	logic [7:0]             head_track;
	logic [7:0]             next_track;

	// server exchange
	logic [7:0]             cpu_command;
	logic [7:0]             cpu_status;

	// sector buffer ports
	logic                   buff_rd_en;
	logic [buff_addr_w-1:0] buff_rd_addr;
	logic [7:0]             buff_rd_data;
	logic                   buff_wr_en;
	logic [buff_addr_w-1:0] buff_wr_addr;
	logic [7:0]             buff_wr_data;

	assign track = head_track;  // physical head position

	fdc_control fdc_control_i (
		.clk          (clk),
		.clken        (clken),
		.reset_n      (reset_n),
		.rd           (rd),
		.wr           (wr),
		.addr         (addr),
		.idata        (idata),
		.odata        (odata),
		.restore      (restore),
		.seek         (seek),
		.step         (step),
		.dir_given    (dir_given),
		.dir          (dir),
		.seek_target  (seek_target),
		.head_track   (head_track),
		.next_track   (next_track),
		.cpu_command  (cpu_command),
		.cpu_status   (cpu_status),
		.sector       (sector),
		.buff_rd_en   (buff_rd_en),
		.buff_rd_addr (buff_rd_addr),
		.buff_rd_data (buff_rd_data),
		.status       (status),
		.irq          (irq),
		.drq          (drq)
	);

	head_positioner head_positioner_i (
		.clk         (clk),
		.clken       (clken),
		.reset_n     (reset_n),
		.restore     (restore),
		.seek        (seek),
		.step        (step),
		.dir_given   (dir_given),
		.dir         (dir),
		.seek_target (seek_target),
		.head_track  (head_track),
		.next_track  (next_track)
	);

	sector_buffer sector_buffer_i (
		.clk     (clk),
		.wr_en   (buff_wr_en),
		.wr_addr (buff_wr_addr),
		.wr_data (buff_wr_data),
		.rd_en   (buff_rd_en),
		.rd_addr (buff_rd_addr),
		.rd_data (buff_rd_data)
	);

	disk_image_server disk_image_server_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.cpu_command (cpu_command),
		.sector      (sector),
		.head_track  (head_track),
		.cpu_status  (cpu_status),
		.wr_en       (buff_wr_en),
		.wr_addr     (buff_wr_addr),
		.wr_data     (buff_wr_data)
	);

endmodule

// File: bench/fdc_chk.sv
`timescale 1ns/1ps

module fdc_chk import fdc_pkg::*; (
	input logic       clk,
	input logic       reset_n,
	input logic [7:0] track,
	input logic [7:0] status,
	input logic       irq,
	input logic       drq
);

	// quiet outputs right after reset
	reset_quiet: assert property (@(posedge clk)
		$rose(reset_n) |-> !irq && !drq && status == 8'h00)
		else $error("irq, drq or status not clear after reset");

	drq_needs_busy: assert property (@(posedge clk) disable iff (!reset_n)
		drq |-> status[sb_busy])
		else $error("drq high without busy");

	irq_drq_apart: assert property (@(posedge clk) disable iff (!reset_n)
		!(irq && drq))
		else $error("irq and drq high together");

	drq_in_status: assert property (@(posedge clk) disable iff (!reset_n)
		drq |-> status[sb_drq])
		else $error("drq output not shown in status");

	// a rejected sector never hands out data
	notfound_no_drq: assert property (@(posedge clk) disable iff (!reset_n)
		status[sb_notfound] |-> !drq)
		else $error("drq high with notfound set");

	busy_ends_with_irq: assert property (@(posedge clk) disable iff (!reset_n)
		$fell(status[sb_busy]) |-> irq)
		else $error("busy fell without irq");

	track0_at_zero: assert property (@(posedge clk) disable iff (!reset_n)
		status[sb_track0] |-> track == 8'd0)
		else $error("track0 set away from track zero");

endmodule

bind fdc_subsystem fdc_chk fdc_chk_i (
	.clk     (clk),
	.reset_n (reset_n),
	.track   (track),
	.status  (status),
	.irq     (irq),
	.drq     (drq)
);

// File: bench/fdc_tb.sv
`timescale 1ns/1ps

module fdc_tb import fdc_pkg::*; ();
	// fill and server exchange per sector, then about eight clocks per data byte
	localparam int sector_reads = 5;
	localparam int timeout_cycles = sector_reads * (1200 + 8 * 512) + 2000;

	logic        clk = 1'b0;
	logic        clken = 1'b1;
	logic        reset_n;
	logic        rd;
	logic        wr;
	logic [2:0]  addr;
	logic [7:0]  idata;
	logic [7:0]  odata;
	logic [7:0]  track;
	logic [7:0]  sector;
	logic [7:0]  status;
	logic        irq;
	logic        drq;
	logic [15:0] lfsr = 16'd8;
	logic [2:0]  en_bits;
	int          value_errors = 0;
	int          event_errors = 0;

	fdc_subsystem fdc_subsystem_i (
		.clk     (clk),
		.clken   (clken),
		.reset_n (reset_n),
		.rd      (rd),
		.wr      (wr),
		.addr    (addr),
		.idata   (idata),
		.odata   (odata),
		.track   (track),
		.sector  (sector),
		.status  (status),
		.irq     (irq),
		.drq     (drq)
	);

	always #4 clk = ~clk;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? (s >> 1) ^ 16'hb400 : s >> 1;
	endfunction

	// clken low when three fresh bits are all zero
	always @(posedge clk) begin
		for (int k = 0; k < 3; k++) begin
			en_bits[k] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		clken <= en_bits != 3'b000;
	end

	// disk image content: low byte of the index, sector, track, side in bit 7
	function automatic logic [7:0] expected_byte(input int i, input logic [7:0] sec,
			input logic [7:0] trk, input logic side);
		logic [7:0] b;
		b = i[7:0] ^ sec ^ trk;
		if (side)
			b[7] = ~b[7];
		return b;
	endfunction

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s expected %h got %h", name, exp, got);
			value_errors++;
		end
	endtask

	task automatic wait_enabled();
		do @(posedge clk); while (!clken);  // edge where the DUT saw clken high
	endtask

	task automatic write_reg(input logic [2:0] a, input logic [7:0] d);
		wr <= 1'b1;
		addr <= a;
		idata <= d;
		wait_enabled();
		wr <= 1'b0;
	endtask

	task automatic read_reg(input logic [2:0] a, output logic [7:0] d);
		rd <= 1'b1;
		addr <= a;
		wait_enabled();
		rd <= 1'b0;
		if (a == a_data) begin
			wait_enabled();  // buffer fetch
			wait_enabled();  // byte to odata
		end
		@(negedge clk);
		d = odata;
		@(posedge clk);
	endtask

	task automatic wait_result(output logic got_drq);
		do @(negedge clk); while (!drq && !irq);
		got_drq = drq;
		@(posedge clk);
	endtask

	task automatic type1(input logic [7:0] cmd, input logic [7:0] exp_track);
		logic [7:0] st;
		write_reg(a_command_status, cmd);
		@(negedge clk);
		check_value("track", track, exp_track);
		check_value("irq", {7'b0, irq}, 8'h01);
		@(posedge clk);
		read_reg(a_command_status, st);
		check_value("odata.track0", {7'b0, st[sb_track0]}, {7'b0, exp_track == 8'd0});
	endtask

	task automatic read_sector(input logic [7:0] sec, input logic [7:0] trk, input logic side);
		logic       got_drq;
		logic [7:0] d;
		wait_result(got_drq);
		if (!got_drq) begin
			$display("read of sector %0d finished without raising drq", sec);
			event_errors++;
		end
		for (int i = 0; i < 512; i++) begin
			read_reg(a_data, d);
			check_value("odata", d, expected_byte(i, sec, trk, side));
		end
	endtask

	task automatic check_read_end();
		@(negedge clk);
		check_value("irq", {7'b0, irq}, 8'h01);
		check_value("drq", {7'b0, drq}, 8'h00);
		check_value("status.busy", {7'b0, status[sb_busy]}, 8'h00);
		@(posedge clk);
	endtask

	task automatic bad_sector(input logic [7:0] sec);
		logic       got_drq;
		logic [7:0] st;
		write_reg(a_sector, sec);
		write_reg(a_command_status, 8'h80);
		wait_result(got_drq);
		if (got_drq) begin
			$display("drq rose for sector %0d, which is not on the track", sec);
			event_errors++;
		end
		read_reg(a_command_status, st);
		check_value("odata.notfound", {7'b0, st[sb_notfound]}, 8'h01);
		check_value("odata.busy", {7'b0, st[sb_busy]}, 8'h00);
	endtask

	initial begin
		logic [7:0] d;
		logic       got_drq;
		reset_n = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		idata = '0;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);

		write_reg(a_track, 8'h2a);
		read_reg(a_track, d);
		check_value("odata", d, 8'h2a);
		write_reg(a_sector, 8'h07);
		read_reg(a_sector, d);
		check_value("odata", d, 8'h07);

		// seek away from the unknown reset position, irq still low
		write_reg(a_track, 8'd20);
		type1(8'h10, 8'd20);

		// restore, three steps in with update, plain step, step out
		type1(8'h00, 8'd0);
		type1(8'h50, 8'd1);
		type1(8'h50, 8'd2);
		type1(8'h50, 8'd3);
		type1(8'h20, 8'd4);
		read_reg(a_track, d);
		check_value("odata", d, 8'd3);  // no update flag
		type1(8'h60, 8'd3);

		write_reg(a_track, 8'd20);
		type1(8'h10, 8'd20);

		// single sector, side 1
		write_reg(a_sector, 8'd5);
		write_reg(a_command_status, 8'h88);
		@(negedge clk);
		check_value("status.busy", {7'b0, status[sb_busy]}, 8'h01);
		@(posedge clk);
		write_reg(a_track, 8'h55);  // while waiting on the server
		read_sector(8'd5, 8'd20, 1'b1);
		check_read_end();
		read_reg(a_track, d);
		check_value("odata", d, 8'd20);

		// refused writes while drq is up
		write_reg(a_sector, 8'd1);
		write_reg(a_command_status, 8'h80);
		wait_result(got_drq);
		write_reg(a_sector, 8'd3);
		write_reg(a_track, 8'h55);
		read_sector(8'd1, 8'd20, 1'b0);
		check_read_end();
		read_reg(a_sector, d);
		check_value("odata", d, 8'd1);
		read_reg(a_track, d);
		check_value("odata", d, 8'd20);

		// multi sector from 9
		write_reg(a_sector, 8'd9);
		write_reg(a_command_status, 8'h90);
		read_sector(8'd9, 8'd20, 1'b0);
		read_sector(8'd10, 8'd20, 1'b0);
		check_read_end();
		read_reg(a_sector, d);
		check_value("odata", d, 8'd10);
		check_value("sector", sector, 8'd10);

		bad_sector(8'd0);
		bad_sector(8'd11);

		$display("value errors: %0d, event errors: %0d", value_errors, event_errors);
		if (value_errors == 0 && event_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("run timed out after %0d clock cycles", timeout_cycles);
		$display("Errors found");
		$finish;
	end

endmodule

// File: fdc_subsystem.f
logic/fdc_pkg.sv
logic/head_positioner.sv
logic/sector_buffer.sv
logic/disk_image_server.sv
logic/fdc_control.sv
logic/fdc_subsystem.sv
bench/fdc_chk.sv
bench/fdc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fdc_tb \
	-f fdc_subsystem.f -o fdc_sim \
	&& ./obj_dir/fdc_sim | tee /dev/stderr | grep -x "No errors" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
